// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // Instruction word and register index sizes
    parameter int INSTR_W    = 32;
    parameter int REG_ADDR_W = 5;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OP_LUI       = 5'b01101,
        OP_AUIPC     = 5'b00101,
        OP_OP_IMM    = 5'b00100,
        OP_OP_IMM_32 = 5'b00110,
        OP_OP        = 5'b01100,
        OP_OP_32     = 5'b01110,
        OP_BRANCH    = 5'b11000,
        OP_JAL       = 5'b11011,
        OP_JALR      = 5'b11001
    } opcode_t;

    // Synchronous exception codes as in mcause
    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGNED = 4'd0,
        EXC_ILLEGAL_INSTR    = 4'd2
    } trap_cause_t;

endpackage

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  wire logic [core_pkg::INSTR_W-1:0]    i_instr,
    output core_pkg::opcode_t                    o_opcode,
    output logic [2:0]                           o_funct3,
    output logic [6:0]                           o_funct7,
    output logic [core_pkg::REG_ADDR_W-1:0]      o_rd,
    output logic [core_pkg::REG_ADDR_W-1:0]      o_rs1,
    output logic [core_pkg::REG_ADDR_W-1:0]      o_rs2,
    output logic [11:0]                          o_i_imm,
    output logic [19:0]                          o_u_imm,
    output logic [12:0]                          o_b_imm,
    output logic [20:0]                          o_j_imm,
    output logic                                 o_is_int,
    output logic                                 o_is_branch
);

    import core_pkg::*;

    // Reserved major opcode, used for words that are not 32-bit encodings
    localparam logic [4:0] OPC_BAD = 5'b11111;

    logic    low_ok;
    opcode_t opcode;

    assign low_ok = i_instr[1:0] == 2'b11;
    assign opcode = low_ok ? opcode_t'(i_instr[6:2]) : opcode_t'(OPC_BAD);

    assign o_opcode = opcode;
    assign o_funct3 = i_instr[14:12];
    assign o_funct7 = i_instr[31:25];
    assign o_rs1    = i_instr[19:15];
    assign o_rs2    = i_instr[24:20];

    // Branches have no destination, their rd field holds offset bits
    assign o_rd = (opcode == OP_BRANCH) ? '0 : i_instr[11:7];

    assign o_i_imm = i_instr[31:20];
    assign o_u_imm = i_instr[31:12];

    // Scattered offsets, bit 0 always zero
    assign o_b_imm = {i_instr[31], i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign o_j_imm = {i_instr[31], i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    // Anything not a control transfer goes to the integer unit,
    // which traps on opcodes it does not know
    assign o_is_branch = opcode inside {OP_BRANCH, OP_JAL, OP_JALR};
    assign o_is_int    = !o_is_branch;

endmodule

`default_nettype wire

// ==== logic/exec_int.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_int #(
    parameter int XLEN = 64,
    parameter int ALEN = 64
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               i_valid,
    input  wire logic               i_is_int,
    input  wire logic [ALEN-1:0]    i_pc,
    input  wire core_pkg::opcode_t  i_opcode,
    input  wire logic [2:0]         i_funct3,
    input  wire logic [11:0]        i_i_imm,
    input  wire logic [19:0]        i_u_imm,
    input  wire logic [XLEN-1:0]    i_rs1_data,
    input  wire logic [XLEN-1:0]    i_rs2_data,
    output logic                    o_valid,
    output logic                    o_exception,
    output core_pkg::trap_cause_t   o_trap_cause,
    output logic [XLEN-1:0]         o_result
);

    import core_pkg::*;

    localparam int SH_W = $clog2(XLEN);

    logic                   is_imm;
    logic                   sub;
    logic [XLEN-1:0]        imm_ext;
    logic [XLEN-1:0]        upper_ext;
    logic [XLEN-1:0]        op_b;
    logic [SH_W-1:0]        shamt;
    logic [4:0]             shamt_w;
    logic [XLEN-1:0]        sum;
    logic signed [XLEN-1:0] sra;
    logic signed [31:0]     sra_w;
    logic                   next_exception;
    logic [XLEN-1:0]        next_result;

    // Sign-extend a word result to the register width
    function automatic logic [XLEN-1:0] sext_w(input logic [31:0] w);
        return XLEN'($signed(w));
    endfunction

    assign is_imm    = i_opcode inside {OP_OP_IMM, OP_OP_IMM_32};
    assign sub       = !is_imm && i_i_imm[10];   // funct7[5] on register forms
    assign imm_ext   = XLEN'($signed(i_i_imm));
    assign upper_ext = XLEN'($signed({i_u_imm, 12'b0}));
    assign op_b      = is_imm ? imm_ext : i_rs2_data;
    assign shamt     = op_b[SH_W-1:0];
    assign shamt_w   = op_b[4:0];

    // Low word of the full sum is also the ADDW/SUBW result
    assign sum   = sub ? i_rs1_data - op_b : i_rs1_data + op_b;
    assign sra   = $signed(i_rs1_data) >>> shamt;
    assign sra_w = $signed(i_rs1_data[31:0]) >>> shamt_w;

    always_comb begin
        next_exception = 1'b0;
        next_result    = '0;
        case (i_opcode)
            OP_LUI:   next_result = upper_ext;
            OP_AUIPC: next_result = XLEN'(i_pc) + upper_ext;
            OP_OP_IMM, OP_OP: begin
                case (i_funct3)
                    3'b000: next_result = sum;                  // ADD/SUB/ADDI
                    3'b001: next_result = i_rs1_data << shamt;
                    3'b010: next_result = XLEN'($signed(i_rs1_data) < $signed(op_b));
                    3'b011: next_result = XLEN'(i_rs1_data < op_b);
                    3'b100: next_result = i_rs1_data ^ op_b;
                    3'b101: next_result = i_i_imm[10] ? sra : i_rs1_data >> shamt;
                    3'b110: next_result = i_rs1_data | op_b;
                    3'b111: next_result = i_rs1_data & op_b;
                    default: next_result = '0;
                endcase
                // Shift immediates leave only funct6 bit 4 free
                if (is_imm && i_funct3 == 3'b001) begin
                    next_exception = i_i_imm[11:SH_W] != '0;
                end
                if (is_imm && i_funct3 == 3'b101) begin
                    next_exception = i_i_imm[11] || i_i_imm[9:SH_W] != '0;
                end
            end
            OP_OP_IMM_32, OP_OP_32: begin
                case (i_funct3)
                    3'b000: next_result = sext_w(sum[31:0]);
                    3'b001: next_result = sext_w(i_rs1_data[31:0] << shamt_w);
                    3'b101: begin
                        next_result = sext_w(i_i_imm[10] ? sra_w : i_rs1_data[31:0] >> shamt_w);
                    end
                    default: next_exception = 1'b1;
                endcase
                if (is_imm && i_funct3 == 3'b001) begin
                    next_exception = i_i_imm[11:5] != '0;
                end
                if (is_imm && i_funct3 == 3'b101) begin
                    next_exception = i_i_imm[11] || i_i_imm[9:5] != '0;
                end
                if (XLEN == 32) begin
                    next_exception = 1'b1;           // No word ops on RV32
                end
            end
            default: next_exception = 1'b1;      // Unknown opcode
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid && i_is_int;
        end
    end

    always_ff @(posedge clk) begin
        o_exception  <= next_exception;
        o_trap_cause <= EXC_ILLEGAL_INSTR;   // only cause this unit can raise
        o_result     <= next_result;
    end

endmodule

`default_nettype wire

// ==== logic/exec_branch.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_branch #(
    parameter int XLEN = 64,
    parameter int ALEN = 64
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               i_valid,
    input  wire logic               i_is_branch,
    input  wire logic [ALEN-1:0]    i_pc,
    input  wire core_pkg::opcode_t  i_opcode,
    input  wire logic [2:0]         i_funct3,
    input  wire logic [11:0]        i_i_imm,
    input  wire logic [12:0]        i_b_imm,
    input  wire logic [20:0]        i_j_imm,
    input  wire logic [XLEN-1:0]    i_rs1_data,
    input  wire logic [XLEN-1:0]    i_rs2_data,
    output logic                    o_valid,
    output logic                    o_exception,
    output core_pkg::trap_cause_t   o_trap_cause,
    output logic [XLEN-1:0]         o_result,
    output logic                    o_redirect,
    output logic [ALEN-1:0]         o_target
);

    import core_pkg::*;

    logic            rs_eq;
    logic            rs_lt;
    logic            rs_ltu;
    logic [ALEN-1:0] br_target;
    logic [ALEN-1:0] jal_target;
    logic [XLEN-1:0] jalr_sum;
    logic [ALEN-1:0] link_pc;
    logic            taken;
    logic            illegal;
    logic            misaligned;
    logic [ALEN-1:0] next_target;

    assign rs_eq  = i_rs1_data == i_rs2_data;
    assign rs_lt  = $signed(i_rs1_data) < $signed(i_rs2_data);
    assign rs_ltu = i_rs1_data < i_rs2_data;

    assign br_target  = i_pc + ALEN'($signed(i_b_imm));
    assign jal_target = i_pc + ALEN'($signed(i_j_imm));
    assign jalr_sum   = i_rs1_data + XLEN'($signed(i_i_imm));
    assign link_pc    = i_pc + ALEN'(4);

    always_comb begin
        taken       = 1'b0;
        illegal     = 1'b0;
        next_target = br_target;
        case (i_opcode)
            OP_BRANCH: begin
                case (i_funct3)
                    3'b000: taken = rs_eq;       // BEQ
                    3'b001: taken = !rs_eq;      // BNE
                    3'b100: taken = rs_lt;       // BLT
                    3'b101: taken = !rs_lt;      // BGE
                    3'b110: taken = rs_ltu;      // BLTU
                    3'b111: taken = !rs_ltu;     // BGEU
                    default: illegal = 1'b1;
                endcase
            end
            OP_JAL: begin
                taken       = 1'b1;
                next_target = jal_target;
            end
            OP_JALR: begin
                taken       = 1'b1;
                next_target = {jalr_sum[ALEN-1:1], 1'b0};
                illegal     = i_funct3 != 3'b000;
            end
            default: illegal = 1'b1;
        endcase
    end

    // No compressed support, so targets must be word aligned
    assign misaligned = taken && next_target[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid && i_is_branch;
        end
    end

    always_ff @(posedge clk) begin
        o_exception  <= illegal || misaligned;
        o_trap_cause <= illegal ? EXC_ILLEGAL_INSTR : EXC_INSTR_MISALIGNED;
        o_result     <= (i_opcode == OP_BRANCH) ? '0 : XLEN'(link_pc);
        o_redirect   <= taken;
        o_target     <= next_target;
    end

endmodule

`default_nettype wire

// ==== logic/exec_writeback.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_writeback #(
    parameter int XLEN = 64,
    parameter int ALEN = 64
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            i_valid,
    input  wire logic [core_pkg::REG_ADDR_W-1:0] i_rd,
    input  wire logic                            i_int_valid,
    input  wire logic                            i_int_exception,
    input  wire core_pkg::trap_cause_t           i_int_trap_cause,
    input  wire logic [XLEN-1:0]                 i_int_result,
    input  wire logic                            i_br_valid,
    input  wire logic                            i_br_exception,
    input  wire core_pkg::trap_cause_t           i_br_trap_cause,
    input  wire logic [XLEN-1:0]                 i_br_result,
    input  wire logic                            i_br_redirect,
    input  wire logic [ALEN-1:0]                 i_br_target,
    output logic                                 o_valid,
    output logic                                 o_exception,
    output core_pkg::trap_cause_t                o_trap_cause,
    output logic                                 o_rd_write,
    output logic [core_pkg::REG_ADDR_W-1:0]      o_rd,
    output logic [XLEN-1:0]                      o_result,
    output logic                                 o_redirect,
    output logic [ALEN-1:0]                      o_target
);

    import core_pkg::*;

    logic                  valid_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic                  retire;
    logic                  exc;
    trap_cause_t           cause;
    logic [XLEN-1:0]       result;

    // Align decoder fields with the unit registers
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        rd_q <= i_rd;
    end

    // Units are mutually exclusive, pick whichever is valid
    assign retire = valid_q && (i_int_valid || i_br_valid);
    assign exc    = i_br_valid ? i_br_exception : i_int_exception;
    assign cause  = i_br_valid ? i_br_trap_cause : i_int_trap_cause;
    assign result = i_br_valid ? i_br_result : i_int_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid    <= 1'b0;
            o_rd_write <= 1'b0;
            o_redirect <= 1'b0;
        end else begin
            o_valid    <= retire;
            o_rd_write <= retire && !exc && rd_q != '0;   // x0 is hardwired
            o_redirect <= retire && i_br_valid && i_br_redirect && !exc;
        end
    end

    always_ff @(posedge clk) begin
        o_exception  <= exc;
        o_trap_cause <= cause;
        o_rd         <= rd_q;
        o_result     <= exc ? '0 : result;
        o_target     <= i_br_target;
    end

endmodule

`default_nettype wire

// ==== logic/exec_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_stage #(
    parameter int XLEN = 64,
    parameter int ALEN = 64
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            i_valid,
    input  wire logic [core_pkg::INSTR_W-1:0]    i_instr,
    input  wire logic [ALEN-1:0]                 i_pc,
    input  wire logic [XLEN-1:0]                 i_rs1_data,
    input  wire logic [XLEN-1:0]                 i_rs2_data,
    output logic                                 o_valid,
    output logic                                 o_exception,
    output core_pkg::trap_cause_t                o_trap_cause,
    output logic                                 o_rd_write,
    output logic [core_pkg::REG_ADDR_W-1:0]      o_rd,
    output logic [XLEN-1:0]                      o_result,
    output logic                                 o_redirect,
    output logic [ALEN-1:0]                      o_target
);

    import core_pkg::*;

    opcode_t               opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [11:0]           i_imm;
    logic [19:0]           u_imm;
    logic [12:0]           b_imm;
    logic [20:0]           j_imm;
    logic                  is_int;
    logic                  is_branch;

    logic                  int_valid;
    logic                  int_exception;
    trap_cause_t           int_cause;
    logic [XLEN-1:0]       int_result;
    logic                  br_valid;
    logic                  br_exception;
    trap_cause_t           br_cause;
    logic [XLEN-1:0]       br_result;
    logic                  br_redirect;
    logic [ALEN-1:0]       br_target;

    // Source indices and funct7 feed the register file side, not this stage
    instr_decoder u_decoder (
        .i_instr     (i_instr),
        .o_opcode    (opcode),
        .o_funct3    (funct3),
        .o_funct7    (),
        .o_rd        (rd),
        .o_rs1       (),
        .o_rs2       (),
        .o_i_imm     (i_imm),
        .o_u_imm     (u_imm),
        .o_b_imm     (b_imm),
        .o_j_imm     (j_imm),
        .o_is_int    (is_int),
        .o_is_branch (is_branch)
    );

    exec_int #(.XLEN(XLEN), .ALEN(ALEN)) u_int (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .i_is_int     (is_int),
        .i_pc         (i_pc),
        .i_opcode     (opcode),
        .i_funct3     (funct3),
        .i_i_imm      (i_imm),
        .i_u_imm      (u_imm),
        .i_rs1_data   (i_rs1_data),
        .i_rs2_data   (i_rs2_data),
        .o_valid      (int_valid),
        .o_exception  (int_exception),
        .o_trap_cause (int_cause),
        .o_result     (int_result)
    );

    exec_branch #(.XLEN(XLEN), .ALEN(ALEN)) u_branch (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .i_is_branch  (is_branch),
        .i_pc         (i_pc),
        .i_opcode     (opcode),
        .i_funct3     (funct3),
        .i_i_imm      (i_imm),
        .i_b_imm      (b_imm),
        .i_j_imm      (j_imm),
        .i_rs1_data   (i_rs1_data),
        .i_rs2_data   (i_rs2_data),
        .o_valid      (br_valid),
        .o_exception  (br_exception),
        .o_trap_cause (br_cause),
        .o_result     (br_result),
        .o_redirect   (br_redirect),
        .o_target     (br_target)
    );

    exec_writeback #(.XLEN(XLEN), .ALEN(ALEN)) u_writeback (
        .clk              (clk),
        .rst              (rst),
        .i_valid          (i_valid),
        .i_rd             (rd),
        .i_int_valid      (int_valid),
        .i_int_exception  (int_exception),
        .i_int_trap_cause (int_cause),
        .i_int_result     (int_result),
        .i_br_valid       (br_valid),
        .i_br_exception   (br_exception),
        .i_br_trap_cause  (br_cause),
        .i_br_result      (br_result),
        .i_br_redirect    (br_redirect),
        .i_br_target      (br_target),
        .o_valid          (o_valid),
        .o_exception      (o_exception),
        .o_trap_cause     (o_trap_cause),
        .o_rd_write       (o_rd_write),
        .o_rd             (o_rd),
        .o_result         (o_result),
        .o_redirect       (o_redirect),
        .o_target         (o_target)
    );

endmodule

`default_nettype wire

// ==== verification/exec_stage_vectors.svh ====
// One row per instruction, issued in table order
// add_row(instr, pc, rs1, rs2, exception, cause, rd_write, result, redirect, target)

// ALU register and immediate forms, first rows go back to back
add_row(32'h002081B3, 'h0, 'h7FFFFFFF, 'h1, 0, 0, 1, 'h80000000, 0, 'h0);
add_row(32'h402081B3, 'h0, 'h5, 'h7, 0, 0, 1, 64'hFFFFFFFFFFFFFFFE, 0, 'h0);
add_row(32'hFFF08193, 'h0, 'h0, 'h0, 0, 0, 1, 64'hFFFFFFFFFFFFFFFF, 0, 'h0);
add_row(32'h0020A1B3, 'h0, 64'hFFFFFFFFFFFFFFFF, 'h1, 0, 0, 1, 'h1, 0, 'h0);
add_row(32'h0020B1B3, 'h0, 64'hFFFFFFFFFFFFFFFF, 'h1, 0, 0, 1, 'h0, 0, 'h0);
add_row(32'h0050A193, 'h0, 64'h8000000000000000, 'h0, 0, 0, 1, 'h1, 0, 'h0);
add_row(32'hFFF0B193, 'h0, 'h1234, 'h0, 0, 0, 1, 'h1, 0, 'h0);
// ADD into x0, no write
add_row(32'h00208033, 'h0, 'h2, 'h3, 0, 0, 0, 'h5, 0, 'h0);
add_row(32'h0020C1B3, 'h0, 'hFF00FF00, 'h0FF00FF0, 0, 0, 1, 'hF0F0F0F0, 0, 'h0);
add_row(32'h0020E1B3, 'h0, 'hF0000000, 'hF, 0, 0, 1, 'hF000000F, 0, 'h0);
add_row(32'h0020F1B3, 'h0, 64'hFFFF0000FFFF0000, 'h0F0F0F0F, 0, 0, 1, 'h0F0F0000, 0, 'h0);
add_row(32'h0F00F193, 'h0, 64'h123456789ABCDEF0, 'h0, 0, 0, 1, 'hF0, 0, 'h0);
// Shifts, SLL takes only the low six bits of rs2
add_row(32'h002091B3, 'h0, 'h1, 'h43, 0, 0, 1, 'h8, 0, 'h0);
add_row(32'h0020D1B3, 'h0, 64'h8000000000000000, 'h3F, 0, 0, 1, 'h1, 0, 'h0);
add_row(32'h4020D1B3, 'h0, 64'h8000000000000000, 'h4, 0, 0, 1, 64'hF800000000000000, 0, 'h0);
add_row(32'h03F09193, 'h0, 'h1, 'h0, 0, 0, 1, 64'h8000000000000000, 0, 'h0);
add_row(32'h03C0D193, 'h0, 64'hF000000000000000, 'h0, 0, 0, 1, 'hF, 0, 'h0);
add_row(32'h4040D193, 'h0, 64'hF000000000000000, 'h0, 0, 0, 1, 64'hFF00000000000000, 0, 'h0);
// LUI and AUIPC
add_row(32'h800001B7, 'h0, 'h0, 'h0, 0, 0, 1, 64'hFFFFFFFF80000000, 0, 'h0);
add_row(32'h12345197, 'h1000, 'h0, 'h0, 0, 0, 1, 'h12346000, 0, 'h0);
// Word forms, sign extended from bit 31
add_row(32'h002081BB, 'h0, 'h7FFFFFFF, 'h1, 0, 0, 1, 64'hFFFFFFFF80000000, 0, 'h0);
add_row(32'h402081BB, 'h0, 64'h100000000, 'h1, 0, 0, 1, 64'hFFFFFFFFFFFFFFFF, 0, 'h0);
add_row(32'h01F0919B, 'h0, 'h1, 'h0, 0, 0, 1, 64'hFFFFFFFF80000000, 0, 'h0);
add_row(32'h4020D1BB, 'h0, 'h80000000, 'h24, 0, 0, 1, 64'hFFFFFFFFF8000000, 0, 'h0);
// Illegal: SLLI reserved bit, OP-32 funct3 010, LOAD, low bits not 11
add_row(32'h04109193, 'h0, 'h1, 'h0, 1, 2, 0, 'h0, 0, 'h0);
add_row(32'h0020A1BB, 'h0, 'h1, 'h1, 1, 2, 0, 'h0, 0, 'h0);
add_row(32'h0000A183, 'h0, 'h1000, 'h0, 1, 2, 0, 'h0, 0, 'h0);
add_row(32'h002081B0, 'h0, 'h1, 'h1, 1, 2, 0, 'h0, 0, 'h0);
// Branches at 0x1000, offsets +16 and -8
add_row(32'h00208863, 'h1000, 'h5, 'h5, 0, 0, 0, 'h0, 1, 'h1010);
add_row(32'h00208863, 'h1000, 'h5, 'h6, 0, 0, 0, 'h0, 0, 'h0);
add_row(32'hFE209CE3, 'h1000, 'h5, 'h6, 0, 0, 0, 'h0, 1, 'hFF8);
add_row(32'h00209863, 'h1000, 'h7, 'h7, 0, 0, 0, 'h0, 0, 'h0);
add_row(32'h0020C863, 'h1000, 64'hFFFFFFFFFFFFFFFF, 'h1, 0, 0, 0, 'h0, 1, 'h1010);
add_row(32'h0020C863, 'h1000, 'h1, 64'hFFFFFFFFFFFFFFFF, 0, 0, 0, 'h0, 0, 'h0);
add_row(32'h0020D863, 'h1000, 'h1, 64'hFFFFFFFFFFFFFFFF, 0, 0, 0, 'h0, 1, 'h1010);
add_row(32'h0020D863, 'h1000, 64'hFFFFFFFFFFFFFFFF, 'h1, 0, 0, 0, 'h0, 0, 'h0);
add_row(32'hFE20ECE3, 'h1000, 'h1, 64'hFFFFFFFFFFFFFFFF, 0, 0, 0, 'h0, 1, 'hFF8);
add_row(32'h0020E863, 'h1000, 64'hFFFFFFFFFFFFFFFF, 'h1, 0, 0, 0, 'h0, 0, 'h0);
add_row(32'h0020F863, 'h1000, 64'hFFFFFFFFFFFFFFFF, 'h1, 0, 0, 0, 'h0, 1, 'h1010);
add_row(32'h0020F863, 'h1000, 'h1, 64'hFFFFFFFFFFFFFFFF, 0, 0, 0, 'h0, 0, 'h0);
// Jumps, then misaligned targets and JALR with funct3 001
add_row(32'h020000EF, 'h2000, 'h0, 'h0, 0, 0, 1, 'h2004, 1, 'h2020);
add_row(32'h005080E7, 'h2100, 'h3000, 'h0, 0, 0, 1, 'h2104, 1, 'h3004);
add_row(32'h006000EF, 'h2000, 'h0, 'h0, 1, 0, 0, 'h0, 0, 'h0);
add_row(32'h002080E7, 'h2100, 'h3000, 'h0, 1, 0, 0, 'h0, 0, 'h0);
add_row(32'h005090E7, 'h2100, 'h3000, 'h0, 1, 2, 0, 'h0, 0, 'h0);

// ==== verification/exec_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_stage_tb;

    import core_pkg::*;

    localparam int PERIOD = 20;
    localparam int XLEN   = 64;
    localparam int ALEN   = 64;
    localparam int BURST  = 8;      // Leading rows sent with no idle cycles

    logic                  clk;
    logic                  rst;
    logic                  i_valid;
    logic [INSTR_W-1:0]    i_instr;
    logic [ALEN-1:0]       i_pc;
    logic [XLEN-1:0]       i_rs1_data;
    logic [XLEN-1:0]       i_rs2_data;
    logic                  o_valid;
    logic                  o_exception;
    trap_cause_t           o_trap_cause;
    logic                  o_rd_write;
    logic [REG_ADDR_W-1:0] o_rd;
    logic [XLEN-1:0]       o_result;
    logic                  o_redirect;
    logic [ALEN-1:0]       o_target;

    // Stimulus and expected values, one entry per row
    logic [31:0] tbl_instr[$];
    logic [63:0] tbl_pc[$];
    logic [63:0] tbl_rs1[$];
    logic [63:0] tbl_rs2[$];
    bit          tbl_exc[$];
    logic [3:0]  tbl_cause[$];
    bit          tbl_wr[$];
    logic [63:0] tbl_result[$];
    bit          tbl_redir[$];
    logic [63:0] tbl_target[$];

    // Rows in flight and the cycle each must retire in
    int pend_row[$];
    int pend_due[$];

    int cur_row;
    int chk_row;
    int chk_due;
    int gap;
    int seed;
    int num_rows     = 0;
    int cycle        = 0;
    int retired      = 0;
    int err_count    = 0;
    int fail_count   = 0;
    bit table_loaded = 1'b0;

    exec_stage #(.XLEN(XLEN), .ALEN(ALEN)) uut (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .i_instr      (i_instr),
        .i_pc         (i_pc),
        .i_rs1_data   (i_rs1_data),
        .i_rs2_data   (i_rs2_data),
        .o_valid      (o_valid),
        .o_exception  (o_exception),
        .o_trap_cause (o_trap_cause),
        .o_rd_write   (o_rd_write),
        .o_rd         (o_rd),
        .o_result     (o_result),
        .o_redirect   (o_redirect),
        .o_target     (o_target)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic add_row(input logic [31:0] instr, input logic [63:0] pc,
                           input logic [63:0] rs1, input logic [63:0] rs2,
                           input bit exc, input logic [3:0] cause, input bit wr,
                           input logic [63:0] result, input bit redir,
                           input logic [63:0] target);
        tbl_instr.push_back(instr);
        tbl_pc.push_back(pc);
        tbl_rs1.push_back(rs1);
        tbl_rs2.push_back(rs2);
        tbl_exc.push_back(exc);
        tbl_cause.push_back(cause);
        tbl_wr.push_back(wr);
        tbl_result.push_back(result);
        tbl_redir.push_back(redir);
        tbl_target.push_back(target);
    endtask

    task automatic load_table;
        `include "exec_stage_vectors.svh"
    endtask

    // Cause only matters on a trap, target on a redirect, rd on a write
    task automatic check_row(input int r);
        logic [31:0] instr;
        instr = tbl_instr[r];
        check($sformatf("row %0d exception", r), o_exception, tbl_exc[r]);
        if (tbl_exc[r]) begin
            check($sformatf("row %0d trap cause", r), o_trap_cause, tbl_cause[r]);
        end
        check($sformatf("row %0d rd write", r), o_rd_write, tbl_wr[r]);
        if (tbl_wr[r]) begin
            check($sformatf("row %0d rd", r), o_rd, instr[11:7]);   // rd field
        end
        check($sformatf("row %0d result", r), o_result, tbl_result[r]);
        check($sformatf("row %0d redirect", r), o_redirect, tbl_redir[r]);
        if (tbl_redir[r]) begin
            check($sformatf("row %0d target", r), o_target, tbl_target[r]);
        end
    endtask

    // Sample away from the clock edge where outputs are settled
    always @(negedge clk) begin
        if (cycle > 0) begin   // Outputs are unknown before the first edge
            if (o_valid === 1'b1) begin
                if (pend_row.size() == 0) begin
                    $display("Unexpected retirement at %0t ns with nothing in flight", $time);
                    fail_count++;
                end else begin
                    chk_row = pend_row.pop_front();
                    chk_due = pend_due.pop_front();
                    retired++;
                    if (cycle != chk_due) begin
                        $display("Row %0d retired in cycle %0d instead of cycle %0d",
                                 chk_row, cycle, chk_due);
                        fail_count++;
                    end
                    check_row(chk_row);
                end
            end else begin
                check("o_valid", o_valid, 1'b0);
                check("o_rd_write", o_rd_write, 1'b0);
                check("o_redirect", o_redirect, 1'b0);
                if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
                    $display("Row %0d never retired, it was due in cycle %0d",
                             pend_row[0], pend_due[0]);
                    fail_count++;
                    chk_row = pend_row.pop_front();
                    chk_due = pend_due.pop_front();
                    retired++;
                end
            end
            if (i_valid === 1'b1) begin
                pend_row.push_back(cur_row);
                pend_due.push_back(cycle + 2);  // Two edges after the drive edge
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        i_valid    = 1'b0;
        i_instr    = '0;
        i_pc       = '0;
        i_rs1_data = '0;
        i_rs2_data = '0;
        cur_row    = 0;
        seed       = 81;
        load_table();
        num_rows     = tbl_instr.size();
        table_loaded = 1'b1;

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < num_rows; r++) begin
            @(posedge clk);
            i_valid    <= 1'b1;
            i_instr    <= tbl_instr[r];
            i_pc       <= tbl_pc[r];
            i_rs1_data <= tbl_rs1[r];
            i_rs2_data <= tbl_rs2[r];
            cur_row    <= r;
            gap = (r < BURST) ? 0 : $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                i_valid <= 1'b0;
            end
        end
        @(posedge clk);
        i_valid <= 1'b0;

        wait (retired == num_rows);
        repeat (2) @(negedge clk);  // Catch any stray retirement
        $display("Value errors: %0d, protocol errors: %0d", err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Three cycles per row covers the widest idle gaps
    initial begin
        wait (table_loaded);
        #((num_rows * 3 + 20) * PERIOD);
        $display("Timeout: not every instruction retired within %0d cycles",
                 num_rows * 3 + 20);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
logic/core_pkg.sv
logic/instr_decoder.sv
logic/exec_int.sv
logic/exec_branch.sv
logic/exec_writeback.sv
logic/exec_stage.sv
verification/exec_stage_tb.sv
